// ==== src.f ====
+incdir+logic
logic/lc_pkg.sv
logic/lc_control.sv
logic/location_counter.sv
logic/instr_word_buffer.sv
logic/macro_instr_unpacker.sv
logic/instr_stream_top.sv
verification/instr_stream_tb.sv

// ==== Makefile ====
# Verilator flow for the instruction stream unit

VERILATOR ?= verilator
TOP       ?= instr_stream_tb
RTL_TOP   ?= instr_stream_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --timing --timescale 1ns/100ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qxF "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/instr_stream_tb.sv ====
// Instruction stream testbench
`include "lc_macros.svh"

module instr_stream_tb;

   timeunit 1ns;
   timeprecision 100ps;

   import lc_pkg::*;

   localparam int CLK_PERIOD   = 8;
   localparam int RESET_CYCLES = 8;
   localparam int NUM_ROWS     = 9;
   localparam int ACK_LIMIT    = 8;  // Longest memory answer plus slack

   typedef struct packed
   {
      logic [`LC_ADDR_W-1:0] load_value;
      logic                  byte_mode;
      rot_op_e               rot_op;
      logic                  sh4_base;
      logic                  sh3_base;
      logic                  use_dispatch;  // Advance by irdisp instead of next_instr
      logic [3:0]            advances;
   } stim_row_t;

   // load value, byte mode, rotate op, sh4 base, sh3 base, dispatch, advances
   stim_row_t rows [NUM_ROWS] = '{
      '{26'h0000100, 1'b0, ROT_BY_LC, 1'b0, 1'b0, 1'b0, 4'd5},
      '{26'h0000204, 1'b1, ROT_BY_LC, 1'b0, 1'b0, 1'b0, 4'd5},
      '{26'h000031a, 1'b0, ROT_BY_LC, 1'b0, 1'b0, 1'b1, 4'd3},  // Load mid-word
      '{26'h0000407, 1'b1, ROT_BY_LC, 1'b0, 1'b0, 1'b1, 4'd4},
      '{26'h0000500, 1'b0, ROT_FIXED, 1'b1, 1'b0, 1'b0, 4'd3},
      '{26'h0000600, 1'b1, ROT_FIXED, 1'b0, 1'b1, 1'b1, 4'd3},
      '{26'h0000702, 1'b0, ROT_BY_LC, 1'b1, 1'b0, 1'b0, 4'd3},
      '{26'h0000801, 1'b1, ROT_BY_LC, 1'b1, 1'b1, 1'b1, 4'd4},
      '{26'h3fffffe, 1'b0, ROT_RSVD2, 1'b1, 1'b1, 1'b1, 4'd2}   // Counter wraps
   };

   logic                  clk;
   logic                  reset;
   logic                  state_fetch;
   logic                  next_instr;
   logic                  irdisp;
   ir_ctl_t               ir;
   logic                  lc_load;
   logic [`LC_ADDR_W-1:0] lc_load_value;
   logic                  byte_mode;
   logic                  ext_int;
   logic                  bus_int;
   logic                  mem_ack;
   logic [`LC_WORD_W-1:0] mem_data;
   fetch_req_t            mem_req;
   logic [`LC_INST_W-1:0] inst;
   logic                  inst_valid;
   logic                  needfetch;
   logic                  sintr;

   logic [`LC_ADDR_W-1:0]  exp_lc;
   logic [`LC_WADDR_W-1:0] exp_waddr;  // Last word address read
   logic                   exp_wrong;  // Word known wrong after a load
   logic                   exp_sintr;
   logic [31:0]            rng_state = 32'hf9bf146e;
   int                     inst_errs = 0;
   int                     fetch_errs = 0;
   int                     bit_errs = 0;
   int                     other_errs = 0;

   instr_stream_top dut0 (.*);  // Port names match the local signals

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Memory contents, a hash of the full word address
   function automatic logic [`LC_WORD_W-1:0] word_at(input logic [`LC_WADDR_W-1:0] waddr);
      return xorshift32(xorshift32({8'ha5, waddr}));
   endfunction

   // Rotate rule applied to a word for a given counter value
   function automatic logic [`LC_INST_W-1:0] rotated_inst(input logic [`LC_WORD_W-1:0] w,
      input logic [`LC_ADDR_W-1:0] lc, input logic bm, input rot_op_e op,
      input logic s4b, input logic s3b);
      logic                  byte_bit;
      logic                  left_half;
      logic                  quarter;
      int                    amount;
      logic [63:0]           doubled;
      logic [`LC_INST_W-1:0] r;
      byte_bit  = bm & lc[0];
      left_half = (op == ROT_BY_LC) && (lc[1] == byte_bit);
      quarter   = (op == ROT_BY_LC) && bm && !lc[0];
      amount    = 16 * int'(s4b ^ left_half) + 8 * int'(s3b ^ quarter);
      doubled   = {w, w} >> amount;
      r         = doubled[`LC_INST_W-1:0];
      if (bm)
         r[`LC_INST_W-1:8] = '0;
      return r;
   endfunction

   // Halfword or byte stored at a byte address
   function automatic logic [`LC_INST_W-1:0] instr_at(input logic [`LC_WORD_W-1:0] w,
      input logic [`LC_ADDR_W-1:0] addr, input logic bm);
      logic [`LC_INST_W-1:0] r;
      if (bm)
         r = {{(`LC_INST_W-8){1'b0}}, w[8*addr[1:0] +: 8]};
      else
         r = w[16*addr[1] +: 16];
      return r;
   endfunction

   task automatic check_inst(input string name, input logic [`LC_INST_W-1:0] got,
      input logic [`LC_INST_W-1:0] exp);
      if (got !== exp)
      begin
         $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
         inst_errs++;
      end
   endtask

   task automatic check_fetch(input string name, input fetch_req_t got,
      input fetch_req_t exp);
      if (got !== exp)
      begin
         $display("[FAIL] t=%0t %s got req=%b waddr=%h expected req=%b waddr=%h",
                  $time, name, got.req, got.waddr, exp.req, exp.waddr);
         fetch_errs++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
         bit_errs++;
      end
   endtask

   task automatic wait_valid();
      int n;
      n = 0;
      while (inst_valid !== 1'b1 && n < ACK_LIMIT)
      begin
         @(negedge clk);
         n++;
      end
      if (inst_valid !== 1'b1)
      begin
         $display("Timeout at %0t: no valid word %0d cycles after a fetch", $time, ACK_LIMIT);
         other_errs++;
      end
   endtask

   // Interrupt lines move between strobes, sintr only on a strobe
   task automatic sample_interrupt(input logic ext, input logic bus);
      @(posedge clk);
      ext_int <= ext;
      bus_int <= bus;
      repeat (2) @(negedge clk);
      check_bit("sintr", sintr, exp_sintr);
      @(posedge clk);
      state_fetch <= 1'b1;
      @(posedge clk);
      state_fetch <= 1'b0;
      exp_sintr = ext | bus;
      @(negedge clk);
      check_bit("sintr", sintr, exp_sintr);
   endtask

   task automatic do_advance(input stim_row_t row);
      logic                  need;
      logic [`LC_ADDR_W-1:0] step;
      logic [`LC_ADDR_W-1:0] cur;
      fetch_req_t            exp_req;
      step = row.byte_mode ? `LC_ADDR_W'(1) : `LC_ADDR_W'(2);
      need = exp_wrong | (!exp_lc[1] && !(row.byte_mode && exp_lc[0]));
      check_bit("needfetch", needfetch, need);
      @(posedge clk);
      state_fetch <= 1'b1;
      if (row.use_dispatch)
      begin
         irdisp              <= 1'b1;
         ir.dispatch_advance <= 1'b1;
      end
      else
      begin
         next_instr <= 1'b1;  // Registered at this strobe
         @(posedge clk);
         next_instr <= 1'b0;
      end
      @(posedge clk);
      state_fetch         <= 1'b0;
      irdisp              <= 1'b0;
      ir.dispatch_advance <= 1'b0;
      @(negedge clk);
      if (need)
         exp_waddr = exp_lc[`LC_ADDR_W-1:2];
      exp_req = '{req: need, waddr: exp_waddr};
      check_fetch("mem_req", mem_req, exp_req);
      cur       = exp_lc;
      exp_lc    = exp_lc + step;
      exp_wrong = 1'b0;
      if (need)
      begin
         check_bit("inst_valid", inst_valid, 1'b0);
         wait_valid();
      end
      check_bit("inst_valid", inst_valid, 1'b1);
      check_inst("inst", inst, rotated_inst(word_at(exp_waddr), exp_lc, row.byte_mode,
                 row.rot_op, row.sh4_base, row.sh3_base));
      if (row.rot_op == ROT_BY_LC && !row.sh4_base && !row.sh3_base)
         check_inst("inst at lc", inst,
                    instr_at(word_at(cur[`LC_ADDR_W-1:2]), cur, row.byte_mode));
   endtask

   task automatic run_row(input stim_row_t row);
      @(posedge clk);
      byte_mode     <= row.byte_mode;
      ir            <= '{rot_op: row.rot_op, sh4_base: row.sh4_base,
                         sh3_base: row.sh3_base, dispatch_advance: 1'b0};
      lc_load       <= 1'b1;
      lc_load_value <= row.load_value;
      state_fetch   <= 1'b1;  // destlc inside a fetch cycle
      @(posedge clk);
      lc_load     <= 1'b0;
      state_fetch <= 1'b0;
      exp_lc    = row.load_value;
      exp_wrong = 1'b1;
      @(negedge clk);
      check_bit("needfetch", needfetch, 1'b1);
      repeat (row.advances) do_advance(row);
   endtask

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Memory answers each read after 1 to 4 cycles
   initial
   begin : memory_model
      logic [`LC_WADDR_W-1:0] waddr;
      int                     lat;
      mem_ack  <= 1'b0;
      mem_data <= '0;
      forever
      begin
         @(posedge clk);
         if (mem_req.req === 1'b1)
         begin
            waddr     = mem_req.waddr;
            rng_state = xorshift32(rng_state);
            lat       = 1 + int'(rng_state[1:0]);
            repeat (lat - 1) @(posedge clk);
            mem_ack  <= 1'b1;
            mem_data <= word_at(waddr);
            @(posedge clk);
            mem_ack <= 1'b0;
         end
      end
   end

   initial
   begin
      #((RESET_CYCLES + NUM_ROWS * 40) * CLK_PERIOD);
      $display("Watchdog expired at %0t, the run did not finish", $time);
      $display("FAIL: see errors above");
      $finish;
   end

   initial
   begin
      reset         <= 1'b1;
      state_fetch   <= 1'b0;
      next_instr    <= 1'b0;
      irdisp        <= 1'b0;
      ir            <= '{rot_op: ROT_FIXED, sh4_base: 1'b0, sh3_base: 1'b0,
                         dispatch_advance: 1'b0};
      lc_load       <= 1'b0;
      lc_load_value <= '0;
      byte_mode     <= 1'b0;
      ext_int       <= 1'b0;
      bus_int       <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_bit("mem_req.req", mem_req.req, 1'b0);
      check_bit("inst_valid", inst_valid, 1'b0);
      check_bit("sintr", sintr, 1'b0);
      check_bit("needfetch", needfetch, 1'b1);  // lc at offset zero
      exp_sintr = 1'b0;
      sample_interrupt(1'b1, 1'b0);
      sample_interrupt(1'b0, 1'b0);
      sample_interrupt(1'b0, 1'b1);
      sample_interrupt(1'b1, 1'b1);
      sample_interrupt(1'b0, 1'b0);
      for (int i = 0; i < NUM_ROWS; i++)
         run_row(rows[i]);
      $display("Errors: inst %0d, fetch %0d, bit %0d, other %0d",
               inst_errs, fetch_errs, bit_errs, other_errs);
      if (inst_errs + fetch_errs + bit_errs + other_errs == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

// ==== logic/instr_stream_top.sv ====
// Macroinstruction stream unit
`include "lc_macros.svh"

module instr_stream_top
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  state_fetch,
   input  logic                  next_instr,
   input  logic                  irdisp,
   input  lc_pkg::ir_ctl_t       ir,
   input  logic                  lc_load,
   input  logic [`LC_ADDR_W-1:0] lc_load_value,
   input  logic                  byte_mode,
   input  logic                  ext_int,
   input  logic                  bus_int,
   input  logic                  mem_ack,
   input  logic [`LC_WORD_W-1:0] mem_data,
   output lc_pkg::fetch_req_t    mem_req,
   output logic [`LC_INST_W-1:0] inst,
   output logic                  inst_valid,
   output logic                  needfetch,
   output logic                  sintr
);

   import lc_pkg::*;

   lc_status_t            lc_status;
   rot_sel_t              rot_sel;
   logic                  lcinc;
   logic                  ifetch;
   logic                  ifetch_taken;
   logic [`LC_WORD_W-1:0] buf_word;

   assign ifetch_taken = state_fetch & ifetch;  // Fetch committed this cycle

   lc_control u_control
   (
      .clk         (clk),
      .reset       (reset),
      .state_fetch (state_fetch),
      .next_instr  (next_instr),
      .irdisp      (irdisp),
      .ir          (ir),
      .lc_load     (lc_load),
      .status      (lc_status),
      .ext_int     (ext_int),
      .bus_int     (bus_int),
      .lcinc       (lcinc),
      .ifetch      (ifetch),
      .needfetch   (needfetch),
      .sintr       (sintr),
      .rot_sel     (rot_sel)
   );

   location_counter u_counter
   (
      .clk           (clk),
      .reset         (reset),
      .state_fetch   (state_fetch),
      .lcinc         (lcinc),
      .ifetch        (ifetch),
      .lc_load       (lc_load),
      .lc_load_value (lc_load_value),
      .byte_mode     (byte_mode),
      .status        (lc_status),
      .mem_req       (mem_req)
   );

   instr_word_buffer u_buffer
   (
      .clk          (clk),
      .reset        (reset),
      .ifetch_taken (ifetch_taken),
      .mem_ack      (mem_ack),
      .mem_data     (mem_data),
      .word         (buf_word),
      .valid        (inst_valid)
   );

   macro_instr_unpacker u_unpacker
   (
      .word      (buf_word),
      .rot_sel   (rot_sel),
      .byte_mode (lc_status.byte_mode),
      .inst      (inst)
   );

endmodule

// ==== logic/macro_instr_unpacker.sv ====
// Macroinstruction unpacker
`include "lc_macros.svh"

module macro_instr_unpacker
(
   input  logic [`LC_WORD_W-1:0] word,
   input  lc_pkg::rot_sel_t      rot_sel,
   input  logic                  byte_mode,
   output logic [`LC_INST_W-1:0] inst
);

   logic [1:0]            rot_bytes;  // Rotate amount in bytes
   logic [`LC_WORD_W-1:0] rotated;

   // 16 * sh4 + 8 * sh3, counted in bytes
   assign rot_bytes = {rot_sel.sh4, rot_sel.sh3};

   // Right rotation on byte boundaries
   always_comb
   begin
      case (rot_bytes)
         2'd0:
         begin
            rotated = word;
         end
         2'd1:
         begin
            rotated = {word[7:0], word[`LC_WORD_W-1:8]};
         end
         2'd2:
         begin
            rotated = {word[15:0], word[`LC_WORD_W-1:16]};
         end
         default:
         begin
            rotated = {word[23:0], word[`LC_WORD_W-1:24]};
         end
      endcase
   end

   /*
    * In byte mode only the low byte is an instruction; the byte above
    * it belongs to the next one and is cleared.
    */
   always_comb
   begin
      if (byte_mode)
         inst = {{(`LC_INST_W-8){1'b0}}, rotated[7:0]};
      else
         inst = rotated[`LC_INST_W-1:0];
   end

endmodule

// ==== logic/instr_word_buffer.sv ====
// Instruction word buffer
`include "lc_macros.svh"

module instr_word_buffer
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  ifetch_taken,
   input  logic                  mem_ack,
   input  logic [`LC_WORD_W-1:0] mem_data,
   output logic [`LC_WORD_W-1:0] word,
   output logic                  valid
);

   import lc_pkg::*;

   buf_state_e state;
   buf_state_e state_next;
   logic       capture;

   // Only an acknowledge for the outstanding read is taken
   assign capture = (state == BUF_WAIT) & mem_ack & ~ifetch_taken;

   always_comb
   begin
      state_next = state;
      case (state)
         BUF_EMPTY:
         begin
            if (ifetch_taken)
               state_next = BUF_WAIT;
         end
         BUF_WAIT:
         begin
            if (ifetch_taken)
               state_next = BUF_WAIT;  // Refetch restarts the wait
            else if (mem_ack)
               state_next = BUF_FULL;
         end
         BUF_FULL:
         begin
            if (ifetch_taken)
               state_next = BUF_WAIT;
         end
         default:
         begin
            state_next = BUF_EMPTY;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= BUF_EMPTY;
      else
         state <= state_next;
   end

   // Word payload
   always_ff @(posedge clk)
   begin
      if (capture)
         word <= mem_data;
   end

   assign valid = (state == BUF_FULL);

endmodule

// ==== logic/location_counter.sv ====
// Location counter register
`include "lc_macros.svh"

module location_counter
(
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   state_fetch,
   input  logic                   lcinc,
   input  logic                   ifetch,
   input  logic                   lc_load,
   input  logic [`LC_ADDR_W-1:0]  lc_load_value,
   input  logic                   byte_mode,
   output lc_pkg::lc_status_t     status,
   output lc_pkg::fetch_req_t     mem_req
);

   logic [`LC_ADDR_W-1:0]  lc;
   logic [`LC_ADDR_W-1:0]  lc_step;
   logic                   step_en;
   logic                   issue;
   logic                   req_q;
   logic [`LC_WADDR_W-1:0] waddr_q;

   assign step_en = state_fetch & lcinc;
   assign issue   = step_en & ifetch;  // Advance that leaves the buffered word

   // One byte in byte mode, one halfword otherwise
   assign lc_step = {{(`LC_ADDR_W-2){1'b0}}, ~byte_mode, byte_mode};

   always_ff @(posedge clk)
   begin
      if (reset)
         lc <= '0;
      else if (lc_load)
         lc <= lc_load_value;  // Load wins over a step
      else if (step_en)
         lc <= lc + lc_step;
   end

   // Read pulse, one cycle after the issuing edge
   always_ff @(posedge clk)
   begin
      if (reset)
         req_q <= 1'b0;
      else
         req_q <= issue;
   end

   // Word address is taken before the step
   always_ff @(posedge clk)
   begin
      if (issue)
         waddr_q <= lc[`LC_ADDR_W-1:2];
   end

   assign status  = '{lc: lc, byte_mode: byte_mode};
   assign mem_req = '{req: req_q, waddr: waddr_q};

endmodule

// ==== logic/lc_control.sv ====
// Location counter control
module lc_control
(
   input  logic                clk,
   input  logic                reset,
   input  logic                state_fetch,
   input  logic                next_instr,
   input  logic                irdisp,
   input  lc_pkg::ir_ctl_t     ir,
   input  logic                lc_load,
   input  lc_pkg::lc_status_t  status,
   input  logic                ext_int,
   input  logic                bus_int,
   output logic                lcinc,
   output logic                ifetch,
   output logic                needfetch,
   output logic                sintr,
   output lc_pkg::rot_sel_t    rot_sel
);

   import lc_pkg::*;

   logic newlc;            // Buffered word no longer matches lc
   logic next_instr_q;     // Advance request seen at last fetch strobe
   logic lc0b;             // Byte bit, zero in word mode
   logic have_wrong_word;
   logic at_word_start;
   logic lc_modifies_rot;
   logic in_left_half;
   logic in_odd_quarter;

   assign lc0b = status.lc[0] & status.byte_mode;

   // Advance from the sequencer or from a dispatch
   assign lcinc = next_instr_q | (irdisp & ir.dispatch_advance);

   assign have_wrong_word = newlc | lc_load;
   assign at_word_start   = ~status.lc[1] & ~lc0b;  // Next step leaves the word
   assign needfetch       = have_wrong_word | at_word_start;
   assign ifetch          = needfetch & lcinc;

   // State sampled once per microinstruction
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         newlc        <= 1'b0;
         next_instr_q <= 1'b0;
         sintr        <= 1'b0;
      end
      else if (state_fetch)
      begin
         newlc        <= have_wrong_word & ~lcinc;  // Cleared once the fetch is taken
         next_instr_q <= next_instr;
         sintr        <= ext_int | bus_int;
      end
   end

   /*
    * lc points one step past the current instruction, so the halfword
    * and byte position are read off the low bits of the next location.
    */
   assign lc_modifies_rot = (ir.rot_op == ROT_BY_LC);
   assign in_left_half    = lc_modifies_rot & (status.lc[1] == lc0b);
   assign in_odd_quarter  = lc_modifies_rot & status.byte_mode & ~status.lc[0];

   assign rot_sel = '{sh4: ir.sh4_base ^ in_left_half,
                      sh3: ir.sh3_base ^ in_odd_quarter};

endmodule

// ==== logic/lc_pkg.sv ====
// Instruction stream types
`include "lc_macros.svh"

package lc_pkg;

   // Memory-rotate opcode field of the microinstruction
   typedef enum logic [1:0]
   {
      ROT_FIXED = 2'b00,  // Rotate by base bits only
      ROT_RSVD1 = 2'b01,
      ROT_RSVD2 = 2'b10,
      ROT_BY_LC = 2'b11   // Location counter adjusts the rotation
   } rot_op_e;

   // Fill state of the instruction word buffer
   typedef enum logic [1:0]
   {
      BUF_EMPTY = 2'b00,
      BUF_WAIT  = 2'b01,  // Read issued, no acknowledge yet
      BUF_FULL  = 2'b10
   } buf_state_e;

   // Microinstruction fields seen by this unit
   typedef struct packed
   {
      rot_op_e rot_op;
      logic    sh4_base;          // Halfword rotate base
      logic    sh3_base;          // Byte rotate base
      logic    dispatch_advance;  // Dispatch also advances the stream
   } ir_ctl_t;

   // Location counter state as seen by control and unpacker
   typedef struct packed
   {
      logic [`LC_ADDR_W-1:0] lc;
      logic                  byte_mode;
   } lc_status_t;

   // Memory read request
   typedef struct packed
   {
      logic                   req;
      logic [`LC_WADDR_W-1:0] waddr;
   } fetch_req_t;

   // Rotate select toward the unpacker
   typedef struct packed
   {
      logic sh4;  // Rotate by 16
      logic sh3;  // Rotate by 8
   } rot_sel_t;

endpackage

// ==== logic/lc_macros.svh ====
// Instruction stream widths
`ifndef LC_MACROS_SVH
`define LC_MACROS_SVH

// Byte address held by the location counter
`define LC_ADDR_W 26

// Memory word as returned on a read
`define LC_WORD_W 32

// One macroinstruction, half of a word
`define LC_INST_W 16

// Word address, the location counter without its two byte bits
`define LC_WADDR_W 24

`endif
